// File: cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// --------------------
// memory depths
// --------------------

// instruction memory, in 32-bit words
`define CPU_IMEM_WORDS 256

// data memory, in 32-bit words
`define CPU_DMEM_WORDS 256

// --------------------
// memory-mapped io
// --------------------

// accesses at or above this go to io
`define CPU_IO_BASE   32'h0000_F000
`define CPU_IO_SWITCH 32'h0000_F000
`define CPU_IO_LED    32'h0000_F004

`endif

// File: cpu_pkg.sv
package cpu_pkg;

    // --------------------
    // instruction formats
    // --------------------

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset is scattered, bit 0 implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one word, read in whichever format the opcode calls for
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // --------------------
    // control
    // --------------------

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU, WB_MEM, WB_PC4
    } wb_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        wb_sel_e wb_sel;
        logic    branch;
        logic    branch_ne;
        logic    jump;
    } ctrl_t;

    // program load port, word address
    typedef struct packed {
        logic [7:0]  addr;
        logic [31:0] data;
    } prog_wr_t;

endpackage

// File: ifetch.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module ifetch (
    input  logic              clk,
    input  logic              rstn_fpga,
    input  logic              prog_we_i,
    input  cpu_pkg::prog_wr_t prog_i,
    input  logic              prog_done_i,
    input  cpu_pkg::ctrl_t    ctrl_i,
    input  logic              zero_i,
    input  logic [31:0]       imm_i,
    output cpu_pkg::inst_t    inst_o,
    output logic [31:0]       pc_o
);

    localparam int IMEM_AW = $clog2(`CPU_IMEM_WORDS);

    logic [31:0] imem [`CPU_IMEM_WORDS];
    logic        run_q;
    logic [31:0] pc_q;
    logic        take;
    logic [31:0] pc_next;

    // loader writes straight into the array
    always_ff @(posedge clk) begin
        if (prog_we_i) begin
            imem[prog_i.addr] <= prog_i.data;
        end
    end

    // --------------------
    // run flag and pc
    // --------------------

    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            run_q <= 1'b0;
            pc_q  <= '0;
        end else begin
            if (prog_done_i) begin
                run_q <= 1'b1;
            end
            if (run_q) begin
                pc_q <= pc_next;
            end
        end
    end

    // bne flips the sense of the zero flag
    assign take    = ctrl_i.jump |
                     (ctrl_i.branch & (ctrl_i.branch_ne ? ~zero_i : zero_i));
    assign pc_next = take ? pc_q + imm_i : pc_q + 32'd4;

    // idle core sees an all-zero word, which decodes to a nop
    assign inst_o = run_q ? imem[pc_q[IMEM_AW+1:2]] : '0;
    assign pc_o   = pc_q;

    a_pc_in_range: assert property (@(posedge clk) disable iff (!rstn_fpga)
        run_q |-> (pc_q[1:0] == 2'b00 && pc_q < `CPU_IMEM_WORDS * 4));

endmodule

// File: controller.sv
`timescale 1ns/1ns

module controller (
    input  cpu_pkg::inst_t inst_i,
    output cpu_pkg::ctrl_t ctrl_o
);

    always_comb begin
        // nop unless an opcode below claims the word
        ctrl_o.alu_op      = cpu_pkg::ALU_ADD;
        ctrl_o.alu_src_imm = 1'b0;
        ctrl_o.mem_read    = 1'b0;
        ctrl_o.mem_write   = 1'b0;
        ctrl_o.reg_write   = 1'b0;
        ctrl_o.wb_sel      = cpu_pkg::WB_ALU;
        ctrl_o.branch      = 1'b0;
        ctrl_o.branch_ne   = 1'b0;
        ctrl_o.jump        = 1'b0;

        case (inst_i.r_fmt.opcode)
            cpu_pkg::OPC_OP: begin
                ctrl_o.reg_write = 1'b1;
                case ({inst_i.r_fmt.funct7, inst_i.r_fmt.funct3})
                    {7'h00, 3'b000}: ctrl_o.alu_op = cpu_pkg::ALU_ADD;
                    {7'h20, 3'b000}: ctrl_o.alu_op = cpu_pkg::ALU_SUB;
                    {7'h00, 3'b111}: ctrl_o.alu_op = cpu_pkg::ALU_AND;
                    {7'h00, 3'b110}: ctrl_o.alu_op = cpu_pkg::ALU_OR;
                    {7'h00, 3'b100}: ctrl_o.alu_op = cpu_pkg::ALU_XOR;
                    {7'h00, 3'b010}: ctrl_o.alu_op = cpu_pkg::ALU_SLT;
                    {7'h00, 3'b001}: ctrl_o.alu_op = cpu_pkg::ALU_SLL;
                    {7'h00, 3'b101}: ctrl_o.alu_op = cpu_pkg::ALU_SRL;
                    default:         ctrl_o.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OPC_OP_IMM: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = 1'b1;
                case (inst_i.i_fmt.funct3)
                    3'b000:  ctrl_o.alu_op = cpu_pkg::ALU_ADD;
                    3'b111:  ctrl_o.alu_op = cpu_pkg::ALU_AND;
                    3'b110:  ctrl_o.alu_op = cpu_pkg::ALU_OR;
                    3'b100:  ctrl_o.alu_op = cpu_pkg::ALU_XOR;
                    default: ctrl_o.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OPC_LUI: begin
                ctrl_o.alu_op      = cpu_pkg::ALU_PASS_B;
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.reg_write   = 1'b1;
            end
            // word accesses only
            cpu_pkg::OPC_LOAD: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_read    = inst_i.i_fmt.funct3 == 3'b010;
                ctrl_o.reg_write   = inst_i.i_fmt.funct3 == 3'b010;
                ctrl_o.wb_sel      = cpu_pkg::WB_MEM;
            end
            cpu_pkg::OPC_STORE: begin
                ctrl_o.alu_src_imm = 1'b1;
                ctrl_o.mem_write   = inst_i.s_fmt.funct3 == 3'b010;
            end
            cpu_pkg::OPC_BRANCH: begin
                ctrl_o.alu_op    = cpu_pkg::ALU_SUB;
                ctrl_o.branch    = inst_i.b_fmt.funct3[2:1] == 2'b00;
                ctrl_o.branch_ne = inst_i.b_fmt.funct3[0];
            end
            cpu_pkg::OPC_JAL: begin
                ctrl_o.jump      = 1'b1;
                ctrl_o.reg_write = 1'b1;
                ctrl_o.wb_sel    = cpu_pkg::WB_PC4;
            end
            default: ;
        endcase
    end

endmodule

// File: decoder.sv
`timescale 1ns/1ns

module decoder (
    input  logic           clk,
    input  cpu_pkg::inst_t inst_i,
    input  cpu_pkg::ctrl_t ctrl_i,
    input  logic [31:0]    alu_result_i,
    input  logic [31:0]    mem_data_i,
    input  logic [31:0]    pc_i,
    output logic [31:0]    rdata1_o,
    output logic [31:0]    rdata2_o,
    output logic [31:0]    imm_o
);

    logic [31:0] regs [32];
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] wb_data;

    assign rs1 = inst_i.r_fmt.rs1;
    assign rs2 = inst_i.r_fmt.rs2;
    assign rd  = inst_i.r_fmt.rd;

    // --------------------
    // register file
    // --------------------

    // x0 reads as zero whatever the array holds
    assign rdata1_o = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rdata2_o = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (ctrl_i.reg_write && rd != 5'd0) begin
            regs[rd] <= wb_data;
        end
    end

    // alu and memory/io results meet here
    always_comb begin
        case (ctrl_i.wb_sel)
            cpu_pkg::WB_MEM: wb_data = mem_data_i;
            cpu_pkg::WB_PC4: wb_data = pc_i + 32'd4;
            default:         wb_data = alu_result_i;
        endcase
    end

    // --------------------
    // immediates
    // --------------------

    always_comb begin
        case (inst_i.r_fmt.opcode)
            cpu_pkg::OPC_OP_IMM,
            cpu_pkg::OPC_LOAD:
                imm_o = {{20{inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
            cpu_pkg::OPC_STORE:
                imm_o = {{20{inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi,
                         inst_i.s_fmt.imm_lo};
            cpu_pkg::OPC_BRANCH:
                imm_o = {{19{inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_12,
                         inst_i.b_fmt.imm_11, inst_i.b_fmt.imm_10_5,
                         inst_i.b_fmt.imm_4_1, 1'b0};
            cpu_pkg::OPC_LUI:
                imm_o = {inst_i.u_fmt.imm_31_12, 12'b0};
            cpu_pkg::OPC_JAL:
                imm_o = {{11{inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_20,
                         inst_i.j_fmt.imm_19_12, inst_i.j_fmt.imm_11,
                         inst_i.j_fmt.imm_10_1, 1'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

// File: alu.sv
`timescale 1ns/1ns

module alu (
    input  cpu_pkg::ctrl_t ctrl_i,
    input  logic [31:0]    rdata1_i,
    input  logic [31:0]    rdata2_i,
    input  logic [31:0]    imm_i,
    output logic [31:0]    result_o,
    output logic           zero_o
);

    logic [31:0] op_b;
    logic [31:0] diff;
    logic [4:0]  shamt;

    assign op_b  = ctrl_i.alu_src_imm ? imm_i : rdata2_i;
    assign diff  = rdata1_i - op_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl_i.alu_op)
            cpu_pkg::ALU_ADD:    result_o = rdata1_i + op_b;
            cpu_pkg::ALU_SUB:    result_o = diff;
            cpu_pkg::ALU_AND:    result_o = rdata1_i & op_b;
            cpu_pkg::ALU_OR:     result_o = rdata1_i | op_b;
            cpu_pkg::ALU_XOR:    result_o = rdata1_i ^ op_b;
            // signed compare
            cpu_pkg::ALU_SLT:
                result_o = {31'b0, $signed(rdata1_i) < $signed(op_b)};
            cpu_pkg::ALU_SLL:    result_o = rdata1_i << shamt;
            cpu_pkg::ALU_SRL:    result_o = rdata1_i >> shamt;
            // lui
            cpu_pkg::ALU_PASS_B: result_o = op_b;
            default:             result_o = '0;
        endcase
    end

    // branch condition, equal operands
    assign zero_o = (diff == 32'd0);

endmodule

// File: mem_or_io.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module mem_or_io (
    input  logic           clk,
    input  logic           rstn_fpga,
    input  cpu_pkg::ctrl_t ctrl_i,
    input  logic [31:0]    addr_i,
    input  logic [31:0]    wdata_i,
    input  logic [15:0]    switch_i,
    output logic [31:0]    rdata_o,
    output logic [15:0]    led_o,
    output logic           led_we_o
);

    localparam int DMEM_AW = $clog2(`CPU_DMEM_WORDS);

    logic [31:0]        dmem [`CPU_DMEM_WORDS];
    logic [DMEM_AW-1:0] d_idx;
    logic               is_mem;
    logic               is_switch;
    logic               is_led;

    // --------------------
    // address steering
    // --------------------

    assign is_mem    = addr_i < `CPU_IO_BASE;
    assign is_switch = addr_i == `CPU_IO_SWITCH;
    assign is_led    = addr_i == `CPU_IO_LED;
    assign d_idx     = addr_i[DMEM_AW+1:2];

    // reads are combinational, same cycle as the load
    always_comb begin
        rdata_o = '0;
        if (ctrl_i.mem_read) begin
            if (is_mem) begin
                rdata_o = dmem[d_idx];
            end else if (is_switch) begin
                rdata_o = {16'b0, switch_i};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.mem_write && is_mem) begin
            dmem[d_idx] <= wdata_i;
        end
    end

    // --------------------
    // led port
    // --------------------

    // strobe lasts one cycle, alongside the new value
    always_ff @(posedge clk) begin
        if (!rstn_fpga) begin
            led_o    <= '0;
            led_we_o <= 1'b0;
        end else begin
            led_we_o <= ctrl_i.mem_write && is_led;
            if (ctrl_i.mem_write && is_led) begin
                led_o <= wdata_i[15:0];
            end
        end
    end

    a_no_rd_wr: assert property (@(posedge clk) disable iff (!rstn_fpga)
        !(ctrl_i.mem_read && ctrl_i.mem_write));

endmodule

// File: cpu.sv
`timescale 1ns/1ns

module cpu (
    input  logic              clk,
    input  logic              rstn_fpga,
    input  logic              prog_we_i,
    input  cpu_pkg::prog_wr_t prog_i,
    input  logic              prog_done_i,
    input  logic [15:0]       switch_i,
    output logic [15:0]       led_o,
    output logic              led_we_o
);

    cpu_pkg::inst_t inst;
    cpu_pkg::ctrl_t ctrl;
    logic [31:0]    pc;
    logic [31:0]    imm;
    logic [31:0]    rdata1;
    logic [31:0]    rdata2;
    logic [31:0]    alu_result;
    logic           zero;
    logic [31:0]    mem_data;

    // --------------------
    // front end
    // --------------------

    ifetch u_ifetch (
        .clk         (clk),
        .rstn_fpga   (rstn_fpga),
        .prog_we_i   (prog_we_i),
        .prog_i      (prog_i),
        .prog_done_i (prog_done_i),
        .ctrl_i      (ctrl),
        .zero_i      (zero),
        .imm_i       (imm),
        .inst_o      (inst),
        .pc_o        (pc)
    );

    controller u_controller (
        .inst_i (inst),
        .ctrl_o (ctrl)
    );

    decoder u_decoder (
        .clk          (clk),
        .inst_i       (inst),
        .ctrl_i       (ctrl),
        .alu_result_i (alu_result),
        .mem_data_i   (mem_data),
        .pc_i         (pc),
        .rdata1_o     (rdata1),
        .rdata2_o     (rdata2),
        .imm_o        (imm)
    );

    // --------------------
    // execute and memory
    // --------------------

    alu u_alu (
        .ctrl_i   (ctrl),
        .rdata1_i (rdata1),
        .rdata2_i (rdata2),
        .imm_i    (imm),
        .result_o (alu_result),
        .zero_o   (zero)
    );

    // address comes from the alu, store data from rs2
    mem_or_io u_mem_or_io (
        .clk       (clk),
        .rstn_fpga (rstn_fpga),
        .ctrl_i    (ctrl),
        .addr_i    (alu_result),
        .wdata_i   (rdata2),
        .switch_i  (switch_i),
        .rdata_o   (mem_data),
        .led_o     (led_o),
        .led_we_o  (led_we_o)
    );

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ns
`include "cpu_cfg.svh"

module tb_cpu;

    localparam logic [31:0] LED_ADDR = `CPU_IO_LED;
    localparam logic [31:0] SW_ADDR  = `CPU_IO_SWITCH;
    localparam int          TIMEOUT  = 5000;
    localparam logic [4:0]  R_LED    = 5'd31;
    localparam logic [4:0]  R_SW     = 5'd30;

    logic              clk;
    logic              rstn_fpga;
    logic              prog_we_i;
    cpu_pkg::prog_wr_t prog_i;
    logic              prog_done_i;
    logic [15:0]       switch_i;
    logic [15:0]       led_o;
    logic              led_we_o;

    logic [31:0]    rng_state;
    cpu_pkg::inst_t prog[$];
    string          prog_tag[$];
    logic [15:0]    exp_led[$];
    string          exp_tag[$];
    logic [15:0]    got_led[$];
    logic           running;
    int             idle_strobes;
    int             led_errs;
    int             count_errs;
    int             other_errs;

    cpu u_cpu (
        .clk         (clk),
        .rstn_fpga   (rstn_fpga),
        .prog_we_i   (prog_we_i),
        .prog_i      (prog_i),
        .prog_done_i (prog_done_i),
        .switch_i    (switch_i),
        .led_o       (led_o),
        .led_we_o    (led_we_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // data registers are x1..x8 only
    function automatic logic [4:0] pick_reg();
        return 5'(1 + xorshift() % 8);
    endfunction

    // --------------------
    // instruction encoders
    // --------------------

    function automatic cpu_pkg::inst_t enc_r(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
        cpu_pkg::inst_t w;
        w.r_fmt = '{f7, rs2, rs1, f3, rd, cpu_pkg::OPC_OP};
        return w;
    endfunction

    function automatic cpu_pkg::inst_t enc_i(logic [6:0] opc, logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [11:0] imm);
        cpu_pkg::inst_t w;
        w.i_fmt = '{imm, rs1, f3, rd, opc};
        return w;
    endfunction

    function automatic cpu_pkg::inst_t enc_s(logic [4:0] rs1, logic [4:0] rs2,
                                             logic [11:0] imm);
        cpu_pkg::inst_t w;
        w.s_fmt = '{imm[11:5], rs2, rs1, 3'b010, imm[4:0], cpu_pkg::OPC_STORE};
        return w;
    endfunction

    function automatic cpu_pkg::inst_t enc_b(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                             logic [12:0] off);
        cpu_pkg::inst_t w;
        w.b_fmt = '{off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], cpu_pkg::OPC_BRANCH};
        return w;
    endfunction

    function automatic cpu_pkg::inst_t enc_u(logic [4:0] rd, logic [19:0] imm);
        cpu_pkg::inst_t w;
        w.u_fmt = '{imm, rd, cpu_pkg::OPC_LUI};
        return w;
    endfunction

    function automatic cpu_pkg::inst_t enc_j(logic [4:0] rd, logic [20:0] off);
        cpu_pkg::inst_t w;
        w.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd, cpu_pkg::OPC_JAL};
        return w;
    endfunction

    task automatic emit(cpu_pkg::inst_t w, string tag);
        prog.push_back(w);
        prog_tag.push_back(tag);
    endtask

    task automatic emit_led(logic [4:0] rs, string tag);
        emit(enc_s(R_LED, rs, 12'd0), tag);
    endtask

    // --------------------
    // program generator
    // --------------------

    task automatic build_program();
        logic [6:0]  r_f7 [8] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00};
        logic [2:0]  r_f3 [8] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5};
        logic [2:0]  i_f3 [4] = '{3'd0, 3'd7, 3'd6, 3'd4};
        logic [31:0] r;
        logic [4:0]  rd;
        logic [11:0] off;
        int          k;
        int          base;
        for (int i = 1; i <= 8; i++) begin
            r = xorshift();
            emit(enc_u(5'(i), r[31:12]), "seed");
            emit(enc_i(cpu_pkg::OPC_OP_IMM, 3'd0, 5'(i), 5'(i), r[11:0]), "seed");
        end
        emit(enc_u(R_LED, LED_ADDR[31:12]), "setup");
        emit(enc_i(cpu_pkg::OPC_OP_IMM, 3'd0, R_LED, R_LED, LED_ADDR[11:0]), "setup");
        emit(enc_u(R_SW, SW_ADDR[31:12]), "setup");
        repeat (12) begin
            k  = xorshift() % 8;
            rd = pick_reg();
            emit(enc_r(r_f7[k], r_f3[k], rd, pick_reg(), pick_reg()), "r_type");
            emit_led(rd, "r_type");
        end
        repeat (10) begin
            k  = xorshift() % 4;
            rd = pick_reg();
            r  = xorshift();
            emit(enc_i(cpu_pkg::OPC_OP_IMM, i_f3[k], rd, pick_reg(), r[11:0]), "i_type");
            emit_led(rd, "i_type");
        end
        repeat (3) begin
            rd = pick_reg();
            r  = xorshift();
            emit(enc_u(rd, r[19:0]), "lui");
            emit_led(rd, "lui");
        end
        // stride 41 is odd, so six word indices never collide
        base = xorshift() % `CPU_DMEM_WORDS;
        for (int i = 0; i < 6; i++) begin
            off = 12'(((base + 41 * i) % `CPU_DMEM_WORDS) * 4);
            emit(enc_s(5'd0, 5'(i + 1), off), "mem_store");
        end
        emit(enc_i(cpu_pkg::OPC_OP_IMM, 3'd0, 5'd21, 5'd0, 12'd16), "mem_setup");
        for (int i = 5; i >= 0; i--) begin
            off = 12'(((base + 41 * i) % `CPU_DMEM_WORDS) * 4);
            emit(enc_i(cpu_pkg::OPC_LOAD, 3'b010, 5'd20, 5'd0, off), "mem_lo");
            emit_led(5'd20, "mem_lo");
            emit(enc_r(7'h00, 3'd5, 5'd22, 5'd20, 5'd21), "mem_hi");
            emit_led(5'd22, "mem_hi");
        end
        // countdown loop whose body is the store plus the decrement
        k = 1 + xorshift() % 6;
        emit(enc_i(cpu_pkg::OPC_OP_IMM, 3'd0, 5'd24, 5'd0, 12'(k)), "loop");
        emit_led(5'd24, "loop");
        emit(enc_i(cpu_pkg::OPC_OP_IMM, 3'd0, 5'd24, 5'd24, 12'hfff), "loop");
        emit(enc_b(3'b001, 5'd24, 5'd0, -13'sd8), "loop");
        emit(enc_b(3'b000, 5'd0, 5'd0, 13'd8), "beq");
        emit_led(5'd1, "beq_skipped");
        emit(enc_j(5'd25, 21'd8), "jal");
        emit_led(5'd2, "jal_skipped");
        emit_led(5'd25, "jal_link");
        emit(enc_i(cpu_pkg::OPC_LOAD, 3'b010, 5'd26, R_SW, 12'd0), "switch");
        emit_led(5'd26, "switch");
        // jump to self ends the program
        emit(enc_j(5'd0, 21'd0), "halt");
    endtask

    // --------------------
    // reference model
    // --------------------

    task automatic run_model();
        logic [31:0]    regs [32];
        logic [31:0]    mem [int];
        cpu_pkg::inst_t w;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    imm;
        logic [31:0]    res;
        logic [31:0]    pc;
        logic [31:0]    npc;
        logic           wr;
        logic           halted;
        int             steps;
        regs   = '{default: '0};
        pc     = '0;
        halted = 1'b0;
        steps  = 0;
        while (!halted && steps < TIMEOUT && pc[31:2] < prog.size()) begin
            w     = prog[pc[31:2]];
            a     = regs[w.r_fmt.rs1];
            b     = regs[w.r_fmt.rs2];
            npc   = pc + 32'd4;
            wr    = 1'b0;
            res   = '0;
            steps++;
            case (w.r_fmt.opcode)
                cpu_pkg::OPC_OP: begin
                    wr = 1'b1;
                    case ({w.r_fmt.funct7, w.r_fmt.funct3})
                        {7'h00, 3'd0}: res = a + b;
                        {7'h20, 3'd0}: res = a - b;
                        {7'h00, 3'd7}: res = a & b;
                        {7'h00, 3'd6}: res = a | b;
                        {7'h00, 3'd4}: res = a ^ b;
                        {7'h00, 3'd2}: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        {7'h00, 3'd1}: res = a << b[4:0];
                        {7'h00, 3'd5}: res = a >> b[4:0];
                        default:       wr = 1'b0;
                    endcase
                end
                cpu_pkg::OPC_OP_IMM: begin
                    imm = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
                    wr  = 1'b1;
                    case (w.i_fmt.funct3)
                        3'd0:    res = a + imm;
                        3'd7:    res = a & imm;
                        3'd6:    res = a | imm;
                        3'd4:    res = a ^ imm;
                        default: wr = 1'b0;
                    endcase
                end
                cpu_pkg::OPC_LUI: begin
                    res = {w.u_fmt.imm_31_12, 12'h000};
                    wr  = 1'b1;
                end
                cpu_pkg::OPC_LOAD: begin
                    imm = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
                    res = (a + imm == SW_ADDR) ? {16'h0, switch_i} :
                          mem[((a + imm) >> 2) % `CPU_DMEM_WORDS];
                    wr  = 1'b1;
                end
                cpu_pkg::OPC_STORE: begin
                    imm = {{20{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
                    if (a + imm == LED_ADDR) begin
                        exp_led.push_back(b[15:0]);
                        exp_tag.push_back(prog_tag[pc[31:2]]);
                    end else begin
                        mem[((a + imm) >> 2) % `CPU_DMEM_WORDS] = b;
                    end
                end
                cpu_pkg::OPC_BRANCH: begin
                    imm = {{19{w.b_fmt.imm_12}}, w.b_fmt.imm_12, w.b_fmt.imm_11,
                           w.b_fmt.imm_10_5, w.b_fmt.imm_4_1, 1'b0};
                    if ((w.b_fmt.funct3 == 3'd0 && a == b) ||
                        (w.b_fmt.funct3 == 3'd1 && a != b)) begin
                        npc = pc + imm;
                    end
                end
                cpu_pkg::OPC_JAL: begin
                    imm = {{11{w.j_fmt.imm_20}}, w.j_fmt.imm_20, w.j_fmt.imm_19_12,
                           w.j_fmt.imm_11, w.j_fmt.imm_10_1, 1'b0};
                    halted = (imm == 32'd0);
                    res    = pc + 32'd4;
                    wr     = 1'b1;
                    npc    = pc + imm;
                end
                default: ;
            endcase
            if (wr && w.r_fmt.rd != 5'd0) begin
                regs[w.r_fmt.rd] = res;
            end
            pc = npc;
        end
        if (!halted) begin
            $display("reference model never reached the halt instruction");
            other_errs++;
        end
    endtask

    // --------------------
    // checks
    // --------------------

    task automatic check_led(string name, logic [15:0] exp, logic [15:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            led_errs++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
            count_errs++;
        end
    endtask

    // outputs are sampled on the falling edge
    always @(negedge clk) begin
        if (rstn_fpga) begin
            if (!running && led_we_o !== 1'b0) begin
                idle_strobes++;
            end
            if (running && led_we_o === 1'b1) begin
                got_led.push_back(led_o);
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          cycles;
        clk          = 1'b0;
        rstn_fpga    = 1'b0;
        prog_we_i    = 1'b0;
        prog_i       = '0;
        prog_done_i  = 1'b0;
        running      = 1'b0;
        idle_strobes = 0;
        led_errs     = 0;
        count_errs   = 0;
        other_errs   = 0;
        rng_state    = 32'd98;
        r            = xorshift();
        switch_i     = r[15:0];
        build_program();
        run_model();

        repeat (2) @(posedge clk);
        rstn_fpga <= 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            prog_we_i <= 1'b1;
            prog_i    <= '{addr: 8'(i), data: prog[i]};
        end
        @(posedge clk);
        prog_we_i <= 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_led("idle_led", 16'h0000, led_o);
        @(posedge clk);
        check_count("idle_strobes", 0, idle_strobes);
        prog_done_i <= 1'b1;
        running = 1'b1;
        @(posedge clk);
        prog_done_i <= 1'b0;

        cycles = 0;
        while (got_led.size() < exp_led.size() && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (got_led.size() < exp_led.size()) begin
            $display("timed out waiting for LED strobes, %0d of %0d seen",
                     got_led.size(), exp_led.size());
            other_errs++;
        end
        // halt loop must stay silent
        repeat (20) @(posedge clk);

        for (int i = 0; i < exp_led.size() && i < got_led.size(); i++) begin
            check_led($sformatf("%s[%0d]", exp_tag[i], i), exp_led[i], got_led[i]);
        end
        check_count("led_strobes", exp_led.size(), got_led.size());
        $display("errors: led %0d, count %0d, other %0d", led_errs, count_errs, other_errs);
        if (led_errs + count_errs + other_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
cpu_pkg.sv
ifetch.sv
controller.sv
decoder.sv
alu.sv
mem_or_io.sv
cpu.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: rv32i_cpu

sources:
  - include_dirs:
      - .
    files:
      - cpu_pkg.sv
      - ifetch.sv
      - controller.sv
      - decoder.sv
      - alu.sv
      - mem_or_io.sv
      - cpu.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cpu.sv
